// ==== rtl/lsu_pkg.sv ====
// load/store issue package
// shared widths, load size codes, the selected operation and byte helpers
package lsu_pkg;

    localparam int XLEN   = 32;
    localparam int NBYTES = XLEN / 8;
    localparam int TAG_W  = 6;

    // funct3 encodings of the load instructions
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_size_t;

    // one operation picked from a queue head
    // for a store, fmask carries the byte write mask
    typedef struct packed {
        logic              is_store;
        load_size_t        size;
        logic [XLEN-1:0]   addr;
        logic [TAG_W-1:0]  tag;
        logic [NBYTES-1:0] fmask;
        logic [XLEN-1:0]   fwd_data;
        logic [XLEN-1:0]   wdata;
    } mem_op_t;

    // bytes of the word touched by a load
    function automatic logic [NBYTES-1:0] load_rmask(input load_size_t size,
                                                     input logic [1:0] off);
        case (size)
            LB, LBU: return NBYTES'(1) << off;
            LH, LHU: return NBYTES'(3) << {off[1], 1'b0};
            default: return '1;
        endcase
    endfunction

    // pick the addressed lane and sign or zero extend it
    function automatic logic [XLEN-1:0] align_load(input load_size_t size,
                                                   input logic [1:0] off,
                                                   input logic [XLEN-1:0] word);
        logic [XLEN-1:0] bsh;
        logic [XLEN-1:0] hsh;
        bsh = word >> {off, 3'b000};
        hsh = word >> {off[1], 4'b0000};
        case (size)
            LB:      return {{(XLEN-8){bsh[7]}}, bsh[7:0]};
            LBU:     return {{(XLEN-8){1'b0}}, bsh[7:0]};
            LH:      return {{(XLEN-16){hsh[15]}}, hsh[15:0]};
            LHU:     return {{(XLEN-16){1'b0}}, hsh[15:0]};
            default: return word;
        endcase
    endfunction

endpackage

// ==== rtl/mem_op_if.sv ====
// operation in flight between the request FSM and the result stage
interface mem_op_if;
    import lsu_pkg::*;

    logic            start;
    mem_op_t         op;
    logic            resp_ok;
    logic [XLEN-1:0] rdata;
    logic            bypass;

    modport source (
        output start,
        output op,
        output resp_ok,
        output rdata,
        output bypass
    );

    modport sink (
        input start,
        input op,
        input resp_ok,
        input rdata,
        input bypass
    );

endinterface

// ==== rtl/issue_select.sv ====
// issue select
// picks the load or store queue head and forms the operation for the cache
module issue_select (
    input  logic                        lq_valid,
    input  logic                        lq_addr_ready,
    input  logic                        lq_dep,
    input  logic [lsu_pkg::XLEN-1:0]    lq_addr,
    input  logic [2:0]                  lq_size,
    input  logic [lsu_pkg::TAG_W-1:0]   lq_tag,
    input  logic [lsu_pkg::NBYTES-1:0]  lq_fwd_mask,
    input  logic [lsu_pkg::XLEN-1:0]    lq_fwd_data,
    input  logic                        sq_valid,
    input  logic                        sq_committed,
    input  logic [lsu_pkg::XLEN-1:0]    sq_addr,
    input  logic [lsu_pkg::NBYTES-1:0]  sq_wmask,
    input  logic [lsu_pkg::XLEN-1:0]    sq_wdata,
    output lsu_pkg::mem_op_t            cand,
    output logic                        cand_valid,
    output logic                        cand_needs_cache
);
    import lsu_pkg::*;

    logic              load_ok;
    logic              store_ok;
    load_size_t        ld_size;
    logic [NBYTES-1:0] ld_fmask;

    assign ld_size = load_size_t'(lq_size);

    // a load with an unresolved older store address must wait
    assign load_ok  = lq_valid && lq_addr_ready && !lq_dep;
    assign store_ok = sq_valid && sq_committed;

    // bytes the queue cannot supply still come from the cache
    assign ld_fmask = load_rmask(ld_size, lq_addr[1:0]) & ~lq_fwd_mask;

    always_comb begin
        cand = '0;
        if (load_ok) begin
            cand.is_store = 1'b0;
            cand.size     = ld_size;
            cand.addr     = lq_addr;
            cand.tag      = lq_tag;
            cand.fmask    = ld_fmask;
            cand.fwd_data = lq_fwd_data;
        end else if (store_ok) begin
            cand.is_store = 1'b1;
            cand.size     = LW;
            cand.addr     = sq_addr;
            cand.fmask    = sq_wmask;
            cand.wdata    = sq_wdata;
        end
    end

    // loads take priority over committed stores
    assign cand_valid       = load_ok || store_ok;
    assign cand_needs_cache = !load_ok || (ld_fmask != '0);

endmodule

// ==== rtl/mem_req_fsm.sv ====
// memory request FSM
// accepts candidates, drives the cache request and tracks the response in flight
module mem_req_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  lsu_pkg::mem_op_t            cand,
    input  logic                        cand_valid,
    input  logic                        cand_needs_cache,
    input  logic                        res_stall,
    input  logic                        busy,
    input  logic [lsu_pkg::XLEN-1:0]    dc_rdata,
    input  logic                        dc_resp,
    output logic                        lq_deq,
    output logic                        sq_deq,
    output logic [lsu_pkg::XLEN-1:0]    dc_addr,
    output logic [lsu_pkg::NBYTES-1:0]  dc_rmask,
    output logic [lsu_pkg::NBYTES-1:0]  dc_wmask,
    output logic [lsu_pkg::XLEN-1:0]    dc_wdata,
    mem_op_if.source                    op_bus
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DROP
    } state_t;

    state_t state;
    state_t state_next;
    logic   cache_free;
    logic   accept;
    logic   req;

    // the cache can take a new request on the cycle its response returns
    assign cache_free = (state == IDLE) || dc_resp;

    // stores ignore a held result since they never broadcast
    always_comb begin
        accept = 1'b0;
        if (cand_valid && !flush) begin
            if (cand.is_store) begin
                accept = cache_free;
            end else begin
                accept = !busy && !res_stall && (cache_free || !cand_needs_cache);
            end
        end
    end

    assign req    = accept && cand_needs_cache;
    assign lq_deq = accept && !cand.is_store;
    assign sq_deq = accept && cand.is_store;

    assign dc_addr  = req ? cand.addr : '0;
    assign dc_rmask = (req && !cand.is_store) ? cand.fmask : '0;
    assign dc_wmask = (req && cand.is_store) ? cand.fmask : '0;
    assign dc_wdata = (req && cand.is_store) ? cand.wdata : '0;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_next = WAIT;
                end
            end
            WAIT: begin
                // a flush leaves the response still to come, so it gets swallowed
                if (flush) begin
                    state_next = dc_resp ? IDLE : DROP;
                end else if (dc_resp) begin
                    state_next = req ? WAIT : IDLE;
                end
            end
            DROP: begin
                if (dc_resp) begin
                    state_next = req ? WAIT : IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign op_bus.start   = accept;
    assign op_bus.op      = cand;
    assign op_bus.bypass  = lq_deq && !cand_needs_cache;
    assign op_bus.rdata   = dc_rdata;
    assign op_bus.resp_ok = (state == WAIT) && dc_resp && !flush;

endmodule

// ==== rtl/load_result_stage.sv ====
// load result stage
// merges forwarded bytes into the cache word, extends it and holds it under stall
module load_result_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        res_stall,
    mem_op_if.sink                      op_bus,
    output logic                        busy,
    output logic                        res_valid,
    output logic [lsu_pkg::TAG_W-1:0]   res_tag,
    output logic [lsu_pkg::XLEN-1:0]    res_value
);
    import lsu_pkg::*;

    mem_op_t         op_q;
    mem_op_t         src_op;
    logic            pend;
    logic            load_start;
    logic            load_done;
    logic [XLEN-1:0] merged;
    logic [XLEN-1:0] value;

    assign load_start = op_bus.start && !op_bus.op.is_store;

    // a bypassed load completes from the queue head in its accept cycle
    assign src_op    = op_bus.bypass ? op_bus.op : op_q;
    assign load_done = op_bus.bypass || (op_bus.resp_ok && pend);

    // fetched bytes come from the cache, the rest from the load queue
    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            if (src_op.fmask[i]) begin
                merged[8*i +: 8] = op_bus.rdata[8*i +: 8];
            end else begin
                merged[8*i +: 8] = src_op.fwd_data[8*i +: 8];
            end
        end
    end

    assign value = align_load(src_op.size, src_op.addr[1:0], merged);

    // the load that is waiting on the cache
    always_ff @(posedge clk) begin
        if (load_start) begin
            op_q <= op_bus.op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pend <= 1'b0;
        end else if (load_start && !op_bus.bypass) begin
            pend <= 1'b1;
        end else if (op_bus.resp_ok) begin
            // store responses land here too and simply clear nothing
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            res_valid <= 1'b0;
        end else if (load_done) begin
            res_valid <= 1'b1;
        end else if (!res_stall) begin
            res_valid <= 1'b0;
        end
    end

    // payload only moves when a new load finishes
    always_ff @(posedge clk) begin
        if (load_done) begin
            res_tag   <= src_op.tag;
            res_value <= value;
        end
    end

    assign busy = res_valid || pend;

endmodule

// ==== rtl/lsu_issue_top.sv ====
// load/store unit issue stage
// selects queue heads, talks to the data cache and broadcasts load results
module lsu_issue_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,

    // load queue head
    input  logic                        lq_valid,
    input  logic                        lq_addr_ready,
    input  logic                        lq_dep,
    input  logic [lsu_pkg::XLEN-1:0]    lq_addr,
    input  logic [2:0]                  lq_size,
    input  logic [lsu_pkg::TAG_W-1:0]   lq_tag,
    input  logic [lsu_pkg::NBYTES-1:0]  lq_fwd_mask,
    input  logic [lsu_pkg::XLEN-1:0]    lq_fwd_data,
    output logic                        lq_deq,

    // store queue head
    input  logic                        sq_valid,
    input  logic                        sq_committed,
    input  logic [lsu_pkg::XLEN-1:0]    sq_addr,
    input  logic [lsu_pkg::NBYTES-1:0]  sq_wmask,
    input  logic [lsu_pkg::XLEN-1:0]    sq_wdata,
    output logic                        sq_deq,

    // data cache
    output logic [lsu_pkg::XLEN-1:0]    dc_addr,
    output logic [lsu_pkg::NBYTES-1:0]  dc_rmask,
    output logic [lsu_pkg::NBYTES-1:0]  dc_wmask,
    output logic [lsu_pkg::XLEN-1:0]    dc_wdata,
    input  logic [lsu_pkg::XLEN-1:0]    dc_rdata,
    input  logic                        dc_resp,

    // result bus
    input  logic                        res_stall,
    output logic                        res_valid,
    output logic [lsu_pkg::TAG_W-1:0]   res_tag,
    output logic [lsu_pkg::XLEN-1:0]    res_value
);
    import lsu_pkg::*;

    mem_op_t cand;
    logic    cand_valid;
    logic    cand_needs_cache;
    logic    busy;

    mem_op_if op_bus ();

    issue_select u_issue_select (
        .lq_valid         (lq_valid),
        .lq_addr_ready    (lq_addr_ready),
        .lq_dep           (lq_dep),
        .lq_addr          (lq_addr),
        .lq_size          (lq_size),
        .lq_tag           (lq_tag),
        .lq_fwd_mask      (lq_fwd_mask),
        .lq_fwd_data      (lq_fwd_data),
        .sq_valid         (sq_valid),
        .sq_committed     (sq_committed),
        .sq_addr          (sq_addr),
        .sq_wmask         (sq_wmask),
        .sq_wdata         (sq_wdata),
        .cand             (cand),
        .cand_valid       (cand_valid),
        .cand_needs_cache (cand_needs_cache)
    );

    mem_req_fsm u_mem_req_fsm (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .cand             (cand),
        .cand_valid       (cand_valid),
        .cand_needs_cache (cand_needs_cache),
        .res_stall        (res_stall),
        .busy             (busy),
        .dc_rdata         (dc_rdata),
        .dc_resp          (dc_resp),
        .lq_deq           (lq_deq),
        .sq_deq           (sq_deq),
        .dc_addr          (dc_addr),
        .dc_rmask         (dc_rmask),
        .dc_wmask         (dc_wmask),
        .dc_wdata         (dc_wdata),
        .op_bus           (op_bus.source)
    );

    load_result_stage u_load_result_stage (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .res_stall (res_stall),
        .op_bus    (op_bus.sink),
        .busy      (busy),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_value (res_value)
    );

endmodule

// ==== tests/lsu_issue_props.sv ====
// cache request protocol checks
// bound into the request FSM
module lsu_issue_props (
    input logic                       clk,
    input logic                       rst,
    input logic [lsu_pkg::NBYTES-1:0] dc_rmask,
    input logic [lsu_pkg::NBYTES-1:0] dc_wmask,
    input logic                       dc_resp
);
    logic req;
    logic outstanding;
    // number of failed assertions
    int   fail_count = 0;

    assign req = (dc_rmask != '0) || (dc_wmask != '0);

    // one response is owed per request
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (req) begin
            outstanding <= 1'b1;
        end else if (dc_resp) begin
            outstanding <= 1'b0;
        end
    end

    a_req_one_cycle: assert property (@(posedge clk) disable iff (rst) req |=> !req)
        else begin
            $error("cache request mask stayed nonzero for two cycles");
            fail_count++;
        end

    // the response cycle may already carry the next request
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        req |-> (!outstanding || dc_resp))
        else begin
            $error("second cache request issued before the response");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge clk) rst |=> (dc_rmask == '0) && (dc_wmask == '0))
        else begin
            $error("cache request masks not zero after reset");
            fail_count++;
        end

endmodule

bind mem_req_fsm lsu_issue_props u_props (
    .clk      (clk),
    .rst      (rst),
    .dc_rmask (dc_rmask),
    .dc_wmask (dc_wmask),
    .dc_resp  (dc_resp)
);

// ==== tests/tb_lsu_issue.sv ====
// testbench for the load/store issue stage
// queue and cache models run from a stimulus file and results are checked in order
module tb_lsu_issue;
    import lsu_pkg::*;

    localparam int NLINES = 20;
    localparam int NCOLS  = 9;
    localparam int PERIOD = 8;

    logic              clk;
    logic              rst;
    logic              flush;
    logic              lq_valid, lq_addr_ready, lq_dep, lq_deq;
    logic [XLEN-1:0]   lq_addr, lq_fwd_data;
    logic [2:0]        lq_size;
    logic [TAG_W-1:0]  lq_tag;
    logic [NBYTES-1:0] lq_fwd_mask;
    logic              sq_valid, sq_committed, sq_deq;
    logic [XLEN-1:0]   sq_addr, sq_wdata;
    logic [NBYTES-1:0] sq_wmask;
    logic [XLEN-1:0]   dc_addr, dc_wdata, dc_rdata;
    logic [NBYTES-1:0] dc_rmask, dc_wmask;
    logic              dc_resp;
    logic              res_stall, res_valid;
    logic [TAG_W-1:0]  res_tag;
    logic [XLEN-1:0]   res_value;

    logic [31:0]       stim [NLINES*NCOLS];
    logic [31:0]       mem [64];
    logic [37:0]       exp_q [$];
    int                errors;
    int                prop_fails;
    logic              held;
    logic [TAG_W-1:0]  held_tag;
    logic [XLEN-1:0]   held_value;

    lsu_issue_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("ERR %0t: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // bytes of the word a load of this funct3 size reads
    function automatic logic [3:0] touched(input logic [2:0] size, input logic [1:0] off);
        case (size[1:0])
            2'b00:   touched = 4'b0001 << off;
            2'b01:   touched = 4'b0011 << off;
            default: touched = 4'b1111;
        endcase
    endfunction

    task automatic put_load(input int n);
        int b;
        b = n * NCOLS;
        lq_valid      = 1'b1;
        lq_addr_ready = 1'b1;
        lq_addr       = stim[b+1];
        lq_size       = stim[b+2][2:0];
        lq_tag        = stim[b+3][5:0];
        lq_fwd_mask   = stim[b+4][3:0];
        lq_fwd_data   = stim[b+5];
    endtask

    task automatic put_store(input int n, input logic committed);
        int b;
        b = n * NCOLS;
        sq_valid     = 1'b1;
        sq_committed = committed;
        sq_addr      = stim[b+1];
        sq_wdata     = stim[b+6];
        sq_wmask     = stim[b+7][3:0];
    endtask

    task automatic take_load(input int n);
        int b;
        b = n * NCOLS;
        do begin
            @(posedge clk);
            check(32'(sq_deq), 32'd0, "store dequeued ahead of a ready load");
        end while (!lq_deq);
        // forwarded bytes never go to the cache
        check(32'(dc_rmask), 32'(touched(lq_size, lq_addr[1:0]) & ~lq_fwd_mask),
              "cache read mask");
        if (stim[b] != 32'd2) begin
            exp_q.push_back({stim[b+3][5:0], stim[b+8]});
        end
        #1;
        lq_valid = 1'b0;
    endtask

    task automatic take_store();
        do begin
            @(posedge clk);
        end while (!sq_deq);
        #1;
        sq_valid = 1'b0;
    endtask

    task automatic drain();
        do begin
            @(posedge clk);
            #1;
        end while (exp_q.size() != 0 || res_valid);
    endtask

    task automatic run_line(input int n);
        logic [31:0] kind;
        kind = stim[n * NCOLS];
        if (kind == 32'd0) begin
            put_store(n, 1'b1);
            take_store();
        end else if (kind == 32'd3) begin
            put_store(n, 1'b0);
            repeat (6) begin
                @(posedge clk);
                check(32'(sq_deq), 32'd0, "uncommitted store dequeued");
            end
            #1;
            // both heads ready in the same cycle
            sq_committed = 1'b1;
            put_load(n);
            take_load(n);
            take_store();
        end else begin
            if (kind == 32'd2) begin
                drain();
            end
            put_load(n);
            take_load(n);
            if (kind == 32'd2) begin
                flush = 1'b1;
                @(posedge clk);
                #1;
                flush = 1'b0;
            end
        end
    endtask

    // cache model that reads and writes at request time and answers 1 to 4 cycles later
    initial begin
        logic [5:0]  idx;
        logic [3:0]  rm;
        logic [3:0]  wm;
        logic [31:0] wd;
        logic [31:0] pend;
        int          wait_cnt;
        dc_resp  = 1'b0;
        dc_rdata = '0;
        pend     = '0;
        wait_cnt = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {4{i[5:0], 2'b11}};
        end
        forever begin
            @(posedge clk);
            rm  = dc_rmask;
            wm  = dc_wmask;
            wd  = dc_wdata;
            idx = dc_addr[7:2];
            #1;
            dc_resp = 1'b0;
            if (wait_cnt > 0) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    dc_resp  = 1'b1;
                    dc_rdata = pend;
                end
            end
            if (rm != '0 || wm != '0) begin
                for (int k = 0; k < 4; k++) begin
                    if (wm[k]) begin
                        mem[idx][8*k +: 8] = wd[8*k +: 8];
                    end
                end
                pend     = mem[idx];
                wait_cnt = $urandom_range(4, 1);
            end
        end
    end

    // stall bursts of one to three cycles
    initial begin
        int burst;
        res_stall = 1'b0;
        burst     = 0;
        forever begin
            @(posedge clk);
            #1;
            if (burst > 0) begin
                burst--;
                res_stall = 1'b1;
            end else if (!rst && $urandom_range(3, 0) == 0) begin
                burst     = $urandom_range(2, 0);
                res_stall = 1'b1;
            end else begin
                res_stall = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (held) begin
                check(32'(res_valid), 32'd1, "result valid dropped under stall");
                check(32'(res_tag), 32'(held_tag), "result tag changed under stall");
                check(res_value, held_value, "result value changed under stall");
            end
            held       = res_valid && res_stall;
            held_tag   = res_tag;
            held_value = res_value;
            if (res_valid && !res_stall) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected result with tag %0d, no load is waiting", res_tag);
                    errors++;
                end else begin
                    check(32'(res_tag), 32'(exp_q[0][37:32]), "result tag");
                    check(res_value, exp_q[0][31:0], "result value");
                    void'(exp_q.pop_front());
                end
            end
            if (!sq_committed && dc_wmask != '0) begin
                $display("an uncommitted store reached the cache at %0t", $time);
                errors++;
            end
        end
    end

    initial begin
        repeat (NLINES * 40) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", NLINES * 40);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(80623));
        errors        = 0;
        prop_fails    = 0;
        held          = 1'b0;
        rst           = 1'b1;
        flush         = 1'b0;
        lq_valid      = 1'b0;
        lq_addr_ready = 1'b0;
        lq_dep        = 1'b0;
        lq_addr       = '0;
        lq_size       = '0;
        lq_tag        = '0;
        lq_fwd_mask   = '0;
        lq_fwd_data   = '0;
        sq_valid      = 1'b0;
        sq_committed  = 1'b1;
        sq_addr       = '0;
        sq_wmask      = '0;
        sq_wdata      = '0;
        $readmemh("tests/lsu_stim.txt", stim);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        for (int n = 0; n < NLINES; n++) begin
            run_line(n);
        end
        drain();
        repeat (8) @(posedge clk);
        prop_fails = dut0.u_mem_req_fsm.u_props.fail_count;
        $display("check errors: %0d, assertion failures: %0d", errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== lsu_issue.f ====
rtl/lsu_pkg.sv
rtl/mem_op_if.sv
rtl/issue_select.sv
rtl/mem_req_fsm.sv
rtl/load_result_stage.sv
rtl/lsu_issue_top.sv
tests/lsu_issue_props.sv
tests/tb_lsu_issue.sv

// ==== Makefile ====
TOOL    := verilator
TOP     := tb_lsu_issue
FLIST   := lsu_issue.f
FLAGS   := --timing --assert
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/lsu_stim.txt ====
// kind addr size tag fmask fdata wdata wmask expected, all hex
// kind 0 store, 1 load, 2 load then flush, 3 late-commit store beside a load (same line)
0 00000010 2 00 0 00000000 f1e2d3c4 f 00000000
0 00000014 2 00 0 00000000 7f6e5d4c f 00000000
0 00000018 2 00 0 00000000 00ab00cd 5 00000000
1 00000010 0 01 0 00000000 00000000 0 ffffffc4
1 00000011 4 02 0 00000000 00000000 0 000000d3
1 00000012 0 03 0 00000000 00000000 0 ffffffe2
1 00000013 4 04 0 00000000 00000000 0 000000f1
1 00000010 1 05 0 00000000 00000000 0 ffffd3c4
1 00000012 5 06 0 00000000 00000000 0 0000f1e2
1 00000014 2 07 0 00000000 00000000 0 7f6e5d4c
1 00000016 1 08 0 00000000 00000000 0 00007f6e
1 00000017 0 09 0 00000000 00000000 0 0000007f
1 00000018 2 0a 0 00000000 00000000 0 1bab1bcd
1 00000020 2 0b f 12345678 00000000 0 12345678
1 00000022 1 0c c ab800000 00000000 0 ffffab80
1 00000014 2 0d 3 00001122 00000000 0 7f6e1122
1 00000012 1 0e 4 00990000 00000000 0 fffff199
2 00000010 2 0f 0 00000000 00000000 0 00000000
3 00000014 2 10 0 00000000 01020304 f 7f6e5d4c
1 00000014 2 11 0 00000000 00000000 0 01020304
